// ==== hw/cache_ctrl.sv ====
/*
 * Cache controller. Registers one CPU request at a time, compares tags
 * of all ways, serves hits in the cycle after sampling and walks the
 * writeback / refill sequence on a miss. Uncached requests bypass the
 * arrays as single-word memory accesses. Memory requests are levels
 * that drop once the matching accept strobe is seen.
 */
module cache_ctrl (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  cache_pkg::cpu_req_t                     cpu_req,
    output cache_pkg::cpu_resp_t                    cpu_resp,
    output cache_pkg::mem_req_t                     mem_req,
    input  cache_pkg::mem_resp_t                    mem_resp,
    output logic [cache_pkg::INDEX_W-1:0]           tag_index,
    output logic [cache_pkg::WAYS-1:0]              tag_we,
    output cache_pkg::tagv_t                        tag_wdata,
    input  cache_pkg::tagv_t [cache_pkg::WAYS-1:0]  tag_rdata,
    output logic [cache_pkg::INDEX_W-1:0]           data_raddr,
    output logic [cache_pkg::INDEX_W-1:0]           data_waddr,
    output logic [cache_pkg::WAYS-1:0]              data_line_we,
    output logic [cache_pkg::WAYS-1:0]              data_word_we,
    output logic [cache_pkg::WSEL_W-1:0]            data_word_sel,
    output logic [3:0]                              data_wstrb,
    output logic [31:0]                             data_wword,
    output cache_pkg::line_t                        data_wline,
    input  cache_pkg::line_t [cache_pkg::WAYS-1:0]  data_rdata,
    output logic                                    lru_access,
    output logic [cache_pkg::WAYS-1:0]              lru_way,
    input  logic [cache_pkg::WAY_W-1:0]             lru_victim
);

    cache_pkg::state_e             state;
    cache_pkg::state_e             state_next;
    cache_pkg::cpu_req_t           req_q;
    logic                          busy;       // request held in req_q
    logic                          sample;
    logic [cache_pkg::TAG_W-1:0]   req_tag;
    logic [cache_pkg::INDEX_W-1:0] req_index;
    logic [cache_pkg::WSEL_W-1:0]  req_word;
    logic [cache_pkg::WAYS-1:0]    hit;
    logic                          cache_hit;
    logic                          store_wr;
    logic                          refill_wr;
    logic [cache_pkg::WAY_W-1:0]   victim_q;
    logic [cache_pkg::WAYS-1:0]    refill_way;
    logic [31:0]                   hit_word;
    logic [31:0]                   unc_rdata;

    assign req_tag   = req_q.addr[31 -: cache_pkg::TAG_W];
    assign req_index = req_q.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign req_word  = req_q.addr[2 +: cache_pkg::WSEL_W];
    assign sample    = (state == cache_pkg::LOOKUP) && !busy && cpu_req.valid;

    always_ff @(posedge clk) begin
        if (sample) begin
            req_q <= cpu_req;
        end
        if (state == cache_pkg::LOOKUP) begin
            victim_q <= lru_victim;  // frozen once we leave lookup
        end
        if (state == cache_pkg::UNC_WAIT && mem_resp.ret_valid) begin
            unc_rdata <= mem_resp.ret_data[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            state <= cache_pkg::LOOKUP;
        end else begin
            state <= state_next;
            if (sample) begin
                busy <= 1'b1;
            end else if (cpu_resp.done) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            hit[w] = tag_rdata[w].valid && (tag_rdata[w].tag == req_tag);
        end
    end

    assign cache_hit = (state == cache_pkg::LOOKUP) && busy && req_q.cached && (|hit);
    assign store_wr  = cache_hit && (req_q.op == cache_pkg::STORE);
    assign refill_wr = (state == cache_pkg::REFILL) && mem_resp.ret_valid;
    assign refill_way = cache_pkg::WAYS'(1) << victim_q;

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::LOOKUP: begin
                if (busy && !req_q.cached) begin
                    state_next = cache_pkg::UNC_REQ;
                end else if (busy && !(|hit)) begin
                    if (tag_rdata[lru_victim].valid && tag_rdata[lru_victim].dirty) begin
                        state_next = cache_pkg::MISS_DIRTY;
                    end else begin
                        state_next = cache_pkg::MISS_CLEAN;
                    end
                end
            end
            cache_pkg::MISS_DIRTY: if (mem_resp.wr_rdy) state_next = cache_pkg::WRITEBACK;
            cache_pkg::WRITEBACK:  if (mem_resp.wr_valid) state_next = cache_pkg::MISS_CLEAN;
            cache_pkg::MISS_CLEAN: if (mem_resp.rd_rdy) state_next = cache_pkg::REFILL;
            cache_pkg::REFILL:     if (mem_resp.ret_valid) state_next = cache_pkg::REFILL_DONE;
            cache_pkg::REFILL_DONE: state_next = cache_pkg::LOOKUP;  // line re-read here
            cache_pkg::UNC_REQ: begin
                if (req_q.op == cache_pkg::LOAD ? mem_resp.rd_rdy : mem_resp.wr_rdy) begin
                    state_next = cache_pkg::UNC_WAIT;
                end
            end
            cache_pkg::UNC_WAIT: begin
                if (req_q.op == cache_pkg::LOAD ? mem_resp.ret_valid : mem_resp.wr_valid) begin
                    state_next = cache_pkg::UNC_DONE;
                end
            end
            cache_pkg::UNC_DONE: state_next = cache_pkg::LOOKUP;
            default: state_next = cache_pkg::LOOKUP;
        endcase
    end

    // array side
    assign tag_index     = req_index;
    assign data_raddr    = busy ? req_index : cpu_req.addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
    assign data_waddr    = req_index;
    assign data_line_we  = refill_wr ? refill_way : '0;
    assign data_word_we  = store_wr ? hit : '0;
    assign data_word_sel = req_word;
    assign data_wstrb    = req_q.wstrb;
    assign data_wword    = req_q.wdata;
    assign data_wline    = mem_resp.ret_data;
    assign tag_we        = refill_wr ? refill_way : (store_wr ? hit : '0);
    assign tag_wdata     = '{valid: 1'b1, dirty: !refill_wr, tag: req_tag};  // refill is clean
    assign lru_access    = cache_hit || refill_wr;
    assign lru_way       = refill_wr ? refill_way : hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (hit[w]) begin
                hit_word |= data_rdata[w][req_word];
            end
        end
    end

    assign cpu_resp.done  = cache_hit || (state == cache_pkg::UNC_DONE);
    assign cpu_resp.rdata = (state == cache_pkg::UNC_DONE) ? unc_rdata : hit_word;

    // memory side
    always_comb begin
        mem_req = '0;
        case (state)
            cache_pkg::MISS_DIRTY: begin
                mem_req.wr_req = 1'b1;
                mem_req.addr   = {tag_rdata[victim_q].tag, req_index,
                                  {cache_pkg::OFFSET_W{1'b0}}};
                mem_req.wstrb  = 4'hf;
                mem_req.wdata  = data_rdata[victim_q];
            end
            cache_pkg::MISS_CLEAN: begin
                mem_req.rd_req = 1'b1;
                mem_req.addr   = {req_tag, req_index, {cache_pkg::OFFSET_W{1'b0}}};
            end
            cache_pkg::UNC_REQ: begin
                mem_req.rd_req   = (req_q.op == cache_pkg::LOAD);
                mem_req.wr_req   = (req_q.op == cache_pkg::STORE);
                mem_req.single   = 1'b1;
                mem_req.addr     = {req_q.addr[31:2], 2'b00};
                mem_req.wstrb    = req_q.wstrb;
                mem_req.wdata[0] = req_q.wdata;
            end
            default: ;
        endcase
    end

    // no two valid ways of a set ever carry the same tag
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(hit));

    // a refill fills one way and never a line that is already present
    assert property (@(posedge clk) disable iff (!rst_n)
                     refill_wr |-> $onehot(data_line_we) && !(|hit));

    assert property (@(posedge clk) disable iff (!rst_n) !(mem_req.rd_req && mem_req.wr_req));

endmodule

// ==== hw/cache_data_array.sv ====
/*
 * Line storage for all ways.
 * One synchronous read port returns the whole set, one write port
 * either replaces a full line (refill) or merges bytes into one word
 * (store hit).
 */
module cache_data_array (
    input  logic                                   clk,
    input  logic [cache_pkg::INDEX_W-1:0]          raddr,
    input  logic [cache_pkg::INDEX_W-1:0]          waddr,
    input  logic [cache_pkg::WAYS-1:0]             line_we,
    input  logic [cache_pkg::WAYS-1:0]             word_we,
    input  logic [cache_pkg::WSEL_W-1:0]           word_sel,
    input  logic [3:0]                             wstrb,
    input  logic [31:0]                            wword,
    input  cache_pkg::line_t                       wline,
    output cache_pkg::line_t [cache_pkg::WAYS-1:0] rdata
);

    cache_pkg::line_t mem [cache_pkg::SETS][cache_pkg::WAYS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (line_we[w]) begin
                mem[waddr][w] <= wline;
            end else if (word_we[w]) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[waddr][w][word_sel][8*b +: 8] <= wword[8*b +: 8];
                    end
                end
            end
            rdata[w] <= mem[raddr][w];  // old data on a same-edge write
        end
    end

    // refill and store hit are separate controller states
    assert property (@(posedge clk) !((|line_we) && (|word_we)));

endmodule

// ==== hw/cache_pkg.sv ====
/*
 * Shared definitions for the 4-way set-associative write-back data cache.
 * Holds the cache geometry, the CPU and memory port structs and the
 * controller state and opcode enums. RTL and testbench refer to these
 * by scoped name.
 */
package cache_pkg;

    // geometry
    localparam int WAYS       = 4;
    localparam int SETS       = 16;
    localparam int LINE_WORDS = 4;
    localparam int OFFSET_W   = 4;  // byte offset within a line
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 24;
    localparam int WAY_W      = $clog2(WAYS);
    localparam int WSEL_W     = OFFSET_W - 2;  // word offset within a line

    typedef logic [LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } op_e;

    typedef struct packed {
        logic        valid;
        op_e         op;
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        cached;
    } cpu_req_t;

    typedef struct packed {
        logic        done;   // one-cycle pulse
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic        rd_req;
        logic        wr_req;
        logic        single;  // word access instead of a whole line
        logic [31:0] addr;
        logic [3:0]  wstrb;
        line_t       wdata;   // word 0 for single writes
    } mem_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  wr_rdy;
        logic  ret_valid;
        line_t ret_data;      // word 0 for single reads
        logic  wr_valid;
    } mem_resp_t;

    typedef enum logic [3:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE,
        UNC_REQ,
        UNC_WAIT,
        UNC_DONE
    } state_e;

endpackage

// ==== hw/cache_plru.sv ====
/*
 * Tree pseudo-LRU replacement, three bits per set.
 * bit 0 picks the half (0 ways 0/1, 1 ways 2/3), bit 1 picks within
 * ways 0/1 and bit 2 within ways 2/3. An access points the bits on
 * its path away from the used way; victim follows the bits.
 */
module cache_plru (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [cache_pkg::INDEX_W-1:0]   index,
    input  logic                            access,
    input  logic [cache_pkg::WAYS-1:0]      way,
    output logic [cache_pkg::WAY_W-1:0]     victim
);

    logic [2:0]                  tree [cache_pkg::SETS];
    logic [2:0]                  cur;
    logic [cache_pkg::WAY_W-1:0] way_num;

    always_comb begin
        way_num = '0;
        for (int i = 0; i < cache_pkg::WAYS; i++) begin
            if (way[i]) begin
                way_num = cache_pkg::WAY_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (access) begin
            if (!way_num[1]) begin
                tree[index][0] <= 1'b1;          // next victim in ways 2/3
                tree[index][1] <= ~way_num[0];
            end else begin
                tree[index][0] <= 1'b0;          // next victim in ways 0/1
                tree[index][2] <= ~way_num[0];
            end
        end
    end

    assign cur    = tree[index];
    assign victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

endmodule

// ==== hw/cache_tag_array.sv ====
/*
 * Valid, dirty and tag storage for all ways of the cache.
 * Read is combinational and returns every way of the addressed set.
 * A write updates only the enabled way of that set.
 */
module cache_tag_array (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [cache_pkg::INDEX_W-1:0]             index,
    input  logic [cache_pkg::WAYS-1:0]                we,
    input  cache_pkg::tagv_t                          wdata,
    output cache_pkg::tagv_t [cache_pkg::WAYS-1:0]    rdata
);

    cache_pkg::tagv_t entry [cache_pkg::SETS][cache_pkg::WAYS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < cache_pkg::WAYS; w++) begin
                    entry[s][w] <= '0;  // all lines invalid
                end
            end
        end else begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                if (we[w]) begin
                    entry[index][w] <= wdata;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            rdata[w] = entry[index][w];
        end
    end

    // refill and store hit never touch more than one way
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(we));

endmodule

// ==== hw/cache_top.sv ====
/*
 * Data cache top level. Connects the controller to the tag array, the
 * data array and the pseudo-LRU block, and exposes the CPU load/store
 * port and the memory port.
 */
module cache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    output cache_pkg::cpu_resp_t cpu_resp,
    output cache_pkg::mem_req_t  mem_req,
    input  cache_pkg::mem_resp_t mem_resp
);

    logic [cache_pkg::INDEX_W-1:0]          tag_index;
    logic [cache_pkg::WAYS-1:0]             tag_we;
    cache_pkg::tagv_t                       tag_wdata;
    cache_pkg::tagv_t [cache_pkg::WAYS-1:0] tag_rdata;
    logic [cache_pkg::INDEX_W-1:0]          data_raddr;
    logic [cache_pkg::INDEX_W-1:0]          data_waddr;
    logic [cache_pkg::WAYS-1:0]             data_line_we;
    logic [cache_pkg::WAYS-1:0]             data_word_we;
    logic [cache_pkg::WSEL_W-1:0]           data_word_sel;
    logic [3:0]                             data_wstrb;
    logic [31:0]                            data_wword;
    cache_pkg::line_t                       data_wline;
    cache_pkg::line_t [cache_pkg::WAYS-1:0] data_rdata;
    logic                                   lru_access;
    logic [cache_pkg::WAYS-1:0]             lru_way;
    logic [cache_pkg::WAY_W-1:0]            lru_victim;

    cache_ctrl ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req       (cpu_req),
        .cpu_resp      (cpu_resp),
        .mem_req       (mem_req),
        .mem_resp      (mem_resp),
        .tag_index     (tag_index),
        .tag_we        (tag_we),
        .tag_wdata     (tag_wdata),
        .tag_rdata     (tag_rdata),
        .data_raddr    (data_raddr),
        .data_waddr    (data_waddr),
        .data_line_we  (data_line_we),
        .data_word_we  (data_word_we),
        .data_word_sel (data_word_sel),
        .data_wstrb    (data_wstrb),
        .data_wword    (data_wword),
        .data_wline    (data_wline),
        .data_rdata    (data_rdata),
        .lru_access    (lru_access),
        .lru_way       (lru_way),
        .lru_victim    (lru_victim)
    );

    cache_tag_array tag_i (
        .clk   (clk),
        .rst_n (rst_n),
        .index (tag_index),
        .we    (tag_we),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    cache_data_array data_i (
        .clk      (clk),
        .raddr    (data_raddr),
        .waddr    (data_waddr),
        .line_we  (data_line_we),
        .word_we  (data_word_we),
        .word_sel (data_word_sel),
        .wstrb    (data_wstrb),
        .wword    (data_wword),
        .wline    (data_wline),
        .rdata    (data_rdata)
    );

    cache_plru plru_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (tag_index),   // same set as the tag lookup
        .access (lru_access),
        .way    (lru_way),
        .victim (lru_victim)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# builds the cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_cache -o tb_cache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== tb.f ====
hw/cache_pkg.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_plru.sv
hw/cache_ctrl.sv
hw/cache_top.sv
verif/tb_cache.sv

// ==== verif/tb_cache.sv ====
/*
 * Testbench for the data cache top level.
 * Drives seeded random loads and stores through the CPU port, answers the
 * memory port with random strobe delays and checks load data, writeback
 * contents, memory traffic per request and done pulses against a memory
 * reference and a residency model with tree pseudo-LRU replacement.
 */
module tb_cache;

    localparam int          NUM_REQ     = 2000;
    localparam int          MAX_CYCLES  = NUM_REQ * 200;
    localparam logic [31:0] SEED        = 32'h70e7_ea28;
    localparam int          NUM_TAGS    = 6;  // more tags than ways, so lines get evicted
    localparam logic [31:0] CACHED_BASE = 32'h0000_4000;  // NUM_TAGS tags from here
    localparam logic [31:0] UNC_BASE    = 32'h0000_8000;  // never cached

    logic                 clk;
    logic                 rst_n;
    cache_pkg::cpu_req_t  cpu_req;
    cache_pkg::cpu_resp_t cpu_resp;
    cache_pkg::mem_req_t  mem_req;
    cache_pkg::mem_resp_t mem_resp;

    logic [31:0] mem_words [logic [31:0]];  // memory behind the cache
    logic [31:0] ref_words [logic [31:0]];  // CPU view of the cached window
    logic        m_valid [cache_pkg::SETS][cache_pkg::WAYS];
    logic        m_dirty [cache_pkg::SETS][cache_pkg::WAYS];
    logic [cache_pkg::TAG_W-1:0] m_tag [cache_pkg::SETS][cache_pkg::WAYS];
    logic [2:0]  m_tree [cache_pkg::SETS];
    int          n_line_rd;
    int          n_line_wr;
    int          n_single;
    logic [31:0] line_rd_addr;
    logic [31:0] line_wr_addr;
    logic [31:0] single_addr;
    logic [3:0]  single_wstrb;
    logic        single_wr;
    logic [31:0] single_wdata;
    int          done_count;

    cache_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    always #10 clk = ~clk;

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9e37_79b9);
    endfunction

    function automatic logic [31:0] read_mem(input logic [31:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end else begin
            return fill_word(a);
        end
    endfunction

    function automatic logic [31:0] read_ref(input logic [31:0] a);
        if (ref_words.exists(a)) begin
            return ref_words[a];
        end else begin
            return fill_word(a);
        end
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // bit 0 picks the half, bit 1 the way in 0/1, bit 2 the way in 2/3
    function automatic int victim_of(input logic [2:0] t);
        return t[0] ? 2 + int'(t[2]) : int'(t[1]);
    endfunction

    function automatic void touch_way(input int set, input int way);
        if (way < 2) begin
            m_tree[set][0] = 1'b1;       // point at the other half
            m_tree[set][1] = (way == 0);
        end else begin
            m_tree[set][0] = 1'b0;
            m_tree[set][2] = (way == 2);
        end
    endfunction

    // expected memory traffic of a cached request, model updated as it goes
    task automatic predict(input logic [31:0] addr, input logic is_store,
                           output int exp_rd, output int exp_wr,
                           output logic [31:0] wb_addr);
        int                          set;
        int                          way;
        logic [cache_pkg::TAG_W-1:0] tag;
        set     = int'(addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W]);
        tag     = addr[31 -: cache_pkg::TAG_W];
        way     = -1;
        exp_rd  = 0;
        exp_wr  = 0;
        wb_addr = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
        end
        if (way < 0) begin
            way    = victim_of(m_tree[set]);
            exp_rd = 1;
            if (m_valid[set][way] && m_dirty[set][way]) begin
                exp_wr  = 1;
                wb_addr = {m_tag[set][way], addr[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W],
                           4'h0};
            end
            m_valid[set][way] = 1'b1;
            m_tag[set][way]   = tag;
            m_dirty[set][way] = 1'b0;  // refill is clean
        end
        touch_way(set, way);
        if (is_store) m_dirty[set][way] = 1'b1;
    endtask

    // one memory transaction, accept strobe and completion after random delays
    task automatic serve_mem();
        cache_pkg::mem_req_t q;
        cache_pkg::line_t    line;
        logic [31:0]         a;
        q    = mem_req;
        line = '0;
        repeat ($urandom_range(3)) @(posedge clk);
        if (q.rd_req) mem_resp.rd_rdy <= 1'b1;
        else mem_resp.wr_rdy <= 1'b1;
        @(posedge clk);
        mem_resp.rd_rdy <= 1'b0;
        mem_resp.wr_rdy <= 1'b0;
        if (q.single) begin
            n_single++;
            single_addr  = q.addr;
            single_wstrb = q.wstrb;
            single_wr    = q.wr_req;
            single_wdata = q.wdata[0];
            if (q.wr_req) mem_words[q.addr] = merge_bytes(read_mem(q.addr), q.wdata[0], q.wstrb);
            else line[0] = read_mem(q.addr);
        end else if (q.rd_req) begin
            n_line_rd++;
            line_rd_addr = q.addr;
            for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
                line[w] = read_mem(q.addr + 32'(4 * w));
            end
        end else begin
            n_line_wr++;
            line_wr_addr = q.addr;
            for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
                a = q.addr + 32'(4 * w);
                compare(q.wdata[w], read_ref(a), "writeback word");
                mem_words[a] = q.wdata[w];
            end
        end
        repeat ($urandom_range(3)) @(posedge clk);
        if (q.rd_req) begin
            mem_resp.ret_data  <= line;
            mem_resp.ret_valid <= 1'b1;
        end else begin
            mem_resp.wr_valid <= 1'b1;
        end
        @(posedge clk);
        mem_resp.ret_valid <= 1'b0;
        mem_resp.wr_valid  <= 1'b0;
    endtask

    // drive at a rising edge, hold until done
    task automatic run_req(input cache_pkg::cpu_req_t r, output logic [31:0] rdata);
        n_line_rd = 0;
        n_line_wr = 0;
        n_single  = 0;
        cpu_req <= r;
        do @(posedge clk); while (!cpu_resp.done);
        rdata = cpu_resp.rdata;
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            compare(32'(cpu_resp.done), 32'd0, "done while idle");
            compare(32'(mem_req.rd_req), 32'd0, "rd_req while idle");
            compare(32'(mem_req.wr_req), 32'd0, "wr_req while idle");
        end
    endtask

    always @(posedge clk) begin
        if (cpu_resp.done) done_count++;
    end

    initial begin : memory_model
        forever begin
            @(posedge clk);
            if (rst_n && (mem_req.rd_req || mem_req.wr_req)) serve_mem();
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles at %0t, DUT appears hung",
                 MAX_CYCLES, $time);
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        cache_pkg::cpu_req_t r;
        logic [31:0]         rdata;
        logic [31:0]         wb_addr;
        int                  exp_rd;
        int                  exp_wr;
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cpu_req    = '0;
        mem_resp   = '0;
        done_count = 0;
        for (int s = 0; s < cache_pkg::SETS; s++) begin
            m_tree[s] = '0;
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_idle(4);

        for (int i = 0; i < NUM_REQ; i++) begin
            r        = '0;
            r.valid  = 1'b1;
            r.cached = ($urandom_range(99) >= 15);
            r.op     = cache_pkg::op_e'($urandom_range(1));
            r.wstrb  = 4'($urandom_range(15, 1));
            r.wdata  = $urandom();
            if (r.cached) begin
                r.addr = CACHED_BASE + $urandom_range(NUM_TAGS - 1) * 32'h100
                         + $urandom_range(63) * 4;
                predict(r.addr, r.op == cache_pkg::STORE, exp_rd, exp_wr, wb_addr);
                run_req(r, rdata);
                compare(32'(n_line_rd), 32'(exp_rd), "line read count");
                if (exp_rd != 0) compare(line_rd_addr, {r.addr[31:4], 4'h0}, "refill address");
                compare(32'(n_line_wr), 32'(exp_wr), "writeback count");
                if (exp_wr != 0) compare(line_wr_addr, wb_addr, "writeback address");
                compare(32'(n_single), 32'd0, "single transfers on cached access");
                if (r.op == cache_pkg::LOAD) compare(rdata, read_ref(r.addr), "cached load data");
                else ref_words[r.addr] = merge_bytes(read_ref(r.addr), r.wdata, r.wstrb);
            end else begin
                r.addr = UNC_BASE + $urandom_range(63) * 4;
                if (r.op == cache_pkg::LOAD && $urandom_range(1) == 1) begin
                    mem_words[r.addr] = $urandom();  // changed behind the cache
                end
                run_req(r, rdata);
                compare(32'(n_single), 32'd1, "single transfer count");
                compare(32'(n_line_rd + n_line_wr), 32'd0, "line transfers on uncached access");
                compare(single_addr, r.addr, "uncached address");
                compare(32'(single_wr), 32'(r.op == cache_pkg::STORE), "uncached direction");
                if (r.op == cache_pkg::STORE) begin
                    compare(32'(single_wstrb), 32'(r.wstrb), "uncached wstrb");
                    compare(single_wdata, r.wdata, "uncached write data");
                end else begin
                    compare(rdata, read_mem(r.addr), "uncached load data");
                end
            end
        end

        cpu_req.valid <= 1'b0;
        check_idle(4);
        compare(32'(done_count), 32'(NUM_REQ), "done pulse count");
        $display("Finished with no errors");
        $finish;
    end

endmodule
